/* source/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data path width of the core, one MIPS word
`define LSU_XLEN 32

// destination register address, 32 GPRs
`define LSU_REG_AW 5

// depth of the data memory in words
`define LSU_MEM_WORDS 256

// word index bits, log2 of the memory depth
`define LSU_MEM_AW 8

`endif

/* source/mips_isa_pkg.sv */
`include "lsu_cfg.svh"

package mips_isa_pkg;

	typedef logic [`LSU_XLEN-1:0] word_t;           // one register or memory word
	typedef logic [`LSU_REG_AW-1:0] reg_addr_t;     // destination register number
	typedef logic [`LSU_XLEN-1:0] byte_addr_t;      // byte address from the execute stage

	// memory operations the unit accepts
	typedef enum logic [3:0]
	{
		OP_LB  = 4'd0,
		OP_LBU = 4'd1,
		OP_LH  = 4'd2,
		OP_LHU = 4'd3,
		OP_LW  = 4'd4,
		OP_SB  = 4'd5,
		OP_SH  = 4'd6,
		OP_SW  = 4'd7,
		OP_LL  = 4'd8,
		OP_SC  = 4'd9
	} mem_op_e;

endpackage

/* source/dmem_pkg.sv */
`include "lsu_cfg.svh"

package dmem_pkg;

	// one enable per byte, bit 3 selects bits 31:24 since the memory is big-endian
	typedef logic [`LSU_XLEN/8-1:0] byte_en_t;

	typedef logic [`LSU_MEM_AW-1:0] word_idx_t;     // word row in the data memory

	typedef logic [1:0] byte_lane_t;                // byte offset, lane 0 is the top byte

endpackage

/* source/lsu_access_if.sv */
`timescale 1ns/1ps

interface lsu_access_if
	import mips_isa_pkg::*, dmem_pkg::*;
	();

	logic valid;
	logic ready;
	mem_op_e op;
	reg_addr_t rd;
	byte_lane_t lane;
	word_idx_t idx;
	byte_en_t be;            // enabled lanes, none for a misaligned halfword
	word_t wdata;            // store data already replicated over all lanes
	logic sc_ok;             // link bit sampled when the sc was accepted

	modport src
	(
		output valid, op, rd, lane, idx, be, wdata, sc_ok,
		input ready
	);

	modport dst
	(
		input valid, op, rd, lane, idx, be, wdata, sc_ok,
		output ready
	);

endinterface

/* source/lsu_result_if.sv */
`timescale 1ns/1ps

interface lsu_result_if
	import mips_isa_pkg::*, dmem_pkg::*;
	();

	logic valid;
	logic ready;
	mem_op_e op;
	reg_addr_t rd;
	byte_lane_t lane;        // still needed to pick the load lane
	word_t rdata;            // whole word read at the access transfer
	logic sc_ok;

	modport src
	(
		output valid, op, rd, lane, rdata, sc_ok,
		input ready
	);

	modport dst
	(
		input valid, op, rd, lane, rdata, sc_ok,
		output ready
	);

endinterface

/* source/lsu_format_stage.sv */
`timescale 1ns/1ps

`include "lsu_cfg.svh"

module lsu_format_stage
	import mips_isa_pkg::*, dmem_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	input logic req_valid_i,
	input mem_op_e req_op_i,
	input byte_addr_t req_addr_i,
	input word_t req_wdata_i,
	input reg_addr_t req_rd_i,
	output logic req_ready_o,
	lsu_access_if.src acc_o
);

	logic req_fire;
	logic link_q;            // set by ll, cleared by any sc
	byte_lane_t lane_d;
	word_idx_t idx_d;
	byte_en_t be_d;
	word_t wdata_d;
	logic sc_ok_d;

	assign req_ready_o = !acc_o.valid || acc_o.ready;      // empty, or draining this cycle
	assign req_fire = req_valid_i && req_ready_o;

	assign lane_d = req_addr_i[1:0];
	assign idx_d = req_addr_i[`LSU_MEM_AW+1:2];            // upper address bits alias
	assign sc_ok_d = (req_op_i == OP_SC) && link_q;

	always_comb
	begin
		be_d = '0;
		wdata_d = req_wdata_i;
		case (req_op_i)
			OP_LB, OP_LBU, OP_SB:
			begin
				be_d = byte_en_t'(4'b1000 >> lane_d);
				wdata_d = {4{req_wdata_i[7:0]}};                // byte shows up in every lane
			end
			OP_LH, OP_LHU, OP_SH:
			begin
				if (!lane_d[0])
					be_d = lane_d[1] ? 4'b0011 : 4'b1100;
				wdata_d = {2{req_wdata_i[15:0]}};
			end
			default:
			begin
				be_d = '1;                                      // lw, sw, ll and sc ignore bits 1:0
			end
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			acc_o.valid <= 1'b0;
		end
		else if (req_fire)
		begin
			acc_o.valid <= 1'b1;
		end
		else if (acc_o.ready)
		begin
			acc_o.valid <= 1'b0;
		end
	end

	// the link bit changes only at acceptance, so request order is kept without a bypass
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			link_q <= 1'b0;
		else if (req_fire && req_op_i == OP_LL)
			link_q <= 1'b1;
		else if (req_fire && req_op_i == OP_SC)
			link_q <= 1'b0;
	end

	always_ff @(posedge clk_i)
	begin
		if (req_fire)
		begin
			acc_o.op <= req_op_i;
			acc_o.rd <= req_rd_i;
			acc_o.lane <= lane_d;
			acc_o.idx <= idx_d;
			acc_o.be <= be_d;
			acc_o.wdata <= wdata_d;
			acc_o.sc_ok <= sc_ok_d;
		end
	end

endmodule

/* source/lsu_access_stage.sv */
`timescale 1ns/1ps

`include "lsu_cfg.svh"

module lsu_access_stage
	import mips_isa_pkg::*, dmem_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	lsu_access_if.dst acc_i,
	lsu_result_if.src res_o
);

	word_t mem_q [`LSU_MEM_WORDS];
	logic acc_fire;
	logic is_store;
	logic mem_we;
	byte_en_t wr_be;

	assign acc_i.ready = !res_o.valid || res_o.ready;
	assign acc_fire = acc_i.valid && acc_i.ready;

	assign is_store = acc_i.op inside {OP_SB, OP_SH, OP_SW};
	assign mem_we = acc_fire && (is_store || (acc_i.op == OP_SC && acc_i.sc_ok));  // failed sc writes nothing
	assign wr_be = mem_we ? acc_i.be : '0;

	always_ff @(posedge clk_i)
	begin
		for (int b = 0; b < `LSU_XLEN/8; b++)
		begin
			if (wr_be[b])
				mem_q[acc_i.idx][b*8 +: 8] <= acc_i.wdata[b*8 +: 8];
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			res_o.valid <= 1'b0;
		end
		else if (acc_fire)
		begin
			res_o.valid <= 1'b1;
		end
		else if (res_o.ready)
		begin
			res_o.valid <= 1'b0;
		end
	end

	// the word is captured only on a transfer, so a stalled result keeps its data
	always_ff @(posedge clk_i)
	begin
		if (acc_fire)
		begin
			res_o.op <= acc_i.op;
			res_o.rd <= acc_i.rd;
			res_o.lane <= acc_i.lane;
			res_o.sc_ok <= acc_i.sc_ok;
			res_o.rdata <= mem_q[acc_i.idx];    // old contents, a store's own data is not needed
		end
	end

endmodule

/* source/lsu_writeback_stage.sv */
`timescale 1ns/1ps

`include "lsu_cfg.svh"

module lsu_writeback_stage
	import mips_isa_pkg::*, dmem_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	lsu_result_if.dst res_i,
	output logic rsp_valid_o,
	output reg_addr_t rsp_rd_o,
	output logic rsp_wen_o,
	output word_t rsp_data_o,
	input logic rsp_ready_i
);

	logic res_fire;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;
	word_t data_d;
	logic wen_d;

	// picks one byte of a big-endian word, lane 0 is bits 31:24
	function automatic logic [7:0] extract_byte(word_t w, byte_lane_t lane);
		return w[(3 - lane)*8 +: 8];
	endfunction

	assign res_i.ready = !rsp_valid_o || rsp_ready_i;
	assign res_fire = res_i.valid && res_i.ready;

	assign byte_sel = extract_byte(res_i.rdata, res_i.lane);
	assign half_sel = res_i.lane[1] ? res_i.rdata[15:0] : res_i.rdata[31:16];
	assign wen_d = !(res_i.op inside {OP_SB, OP_SH, OP_SW});   // plain stores write no register

	always_comb
	begin
		data_d = '0;
		case (res_i.op)
			OP_LB:  data_d = {{(`LSU_XLEN-8){byte_sel[7]}}, byte_sel};
			OP_LBU: data_d = {{(`LSU_XLEN-8){1'b0}}, byte_sel};
			OP_LH:
			begin
				if (!res_i.lane[0])
					data_d = {{(`LSU_XLEN-16){half_sel[15]}}, half_sel};
			end
			OP_LHU:
			begin
				if (!res_i.lane[0])
					data_d = {{(`LSU_XLEN-16){1'b0}}, half_sel};   // misaligned stays zero
			end
			OP_LW, OP_LL: data_d = res_i.rdata;
			OP_SC: data_d = word_t'(res_i.sc_ok);     // 1 on success, 0 otherwise
			default: data_d = '0;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			rsp_valid_o <= 1'b0;
		end
		else if (res_fire)
		begin
			rsp_valid_o <= 1'b1;
		end
		else if (rsp_ready_i)
		begin
			rsp_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (res_fire)
		begin
			rsp_rd_o <= res_i.rd;
			rsp_wen_o <= wen_d;
			rsp_data_o <= data_d;
		end
	end

endmodule

/* source/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top
	import mips_isa_pkg::*;
(
	input logic clk_i,
	input logic rst_i,

	// request side
	input logic req_valid_i,
	output logic req_ready_o,
	input mem_op_e req_op_i,
	input byte_addr_t req_addr_i,
	input word_t req_wdata_i,
	input reg_addr_t req_rd_i,

	// response side, one per request in order
	output logic rsp_valid_o,
	input logic rsp_ready_i,
	output reg_addr_t rsp_rd_o,
	output logic rsp_wen_o,
	output word_t rsp_data_o
);

	lsu_access_if acc_if ();
	lsu_result_if res_if ();

	lsu_format_stage format_i
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_op_i    (req_op_i),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.req_rd_i    (req_rd_i),
		.req_ready_o (req_ready_o),
		.acc_o       (acc_if.src)
	);

	lsu_access_stage access_i
	(
		.clk_i (clk_i),
		.rst_i (rst_i),
		.acc_i (acc_if.dst),
		.res_o (res_if.src)
	);

	lsu_writeback_stage writeback_i
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.res_i       (res_if.dst),
		.rsp_valid_o (rsp_valid_o),
		.rsp_rd_o    (rsp_rd_o),
		.rsp_wen_o   (rsp_wen_o),
		.rsp_data_o  (rsp_data_o),
		.rsp_ready_i (rsp_ready_i)
	);

endmodule

/* tb/lsu_properties.sv */
`timescale 1ns/1ps

module lsu_properties
	import mips_isa_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	input logic req_valid_i,
	input logic req_ready_i,
	input logic acc_valid_i,
	input logic res_valid_i,
	input logic res_ready_i,
	input mem_op_e res_op_i,
	input logic rsp_valid_i,
	input logic rsp_ready_i,
	input reg_addr_t rsp_rd_i,
	input logic rsp_wen_i,
	input word_t rsp_data_i
);

	// a stalled response holds until the sink takes it
	rsp_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rd_i)
			&& $stable(rsp_wen_i) && $stable(rsp_data_i))
	else $error("response changed while rsp_ready_i was low");

	// with every stage empty the format stage must take the request and hold it next cycle
	req_accept_a: assert property (@(posedge clk_i) disable iff (rst_i)
		req_valid_i && !acc_valid_i && !res_valid_i && !rsp_valid_i
			|-> req_ready_i ##1 acc_valid_i)
	else $error("request refused while the pipeline was empty");

	// the write-back register loads the store's response on this transfer
	store_wen_a: assert property (@(posedge clk_i) disable iff (rst_i)
		res_valid_i && res_ready_i && (res_op_i inside {OP_SB, OP_SH, OP_SW}) |=> !rsp_wen_i)
	else $error("response to a plain store has rsp_wen_o set");

endmodule

/* tb/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb
	import mips_isa_pkg::*;
();

	localparam int SEND_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 2000;

	logic clk_i;
	logic rst_i;
	logic req_valid_i;
	logic req_ready_o;
	mem_op_e req_op_i;
	byte_addr_t req_addr_i;
	word_t req_wdata_i;
	reg_addr_t req_rd_i;
	logic rsp_valid_o;
	logic rsp_ready_i;
	reg_addr_t rsp_rd_o;
	logic rsp_wen_o;
	word_t rsp_data_o;

	integer seed = 32'h513c_4dd6;
	word_t model_mem [16];            // mirror of the words the stimulus can reach
	logic model_link;
	logic [37:0] exp_q [$];           // {wen, rd, data} for every accepted request
	string cur_test;
	int errors;
	int test_start_errors;
	int tests_passed;
	int tests_failed;
	logic bp_mode;                    // random rsp_ready_i when set
	logic timed_out;

	lsu_top lsu_top_i (.*);

	bind lsu_top lsu_properties props_i
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_ready_i (req_ready_o),
		.acc_valid_i (acc_if.valid),
		.res_valid_i (res_if.valid),
		.res_ready_i (res_if.ready),
		.res_op_i    (res_if.op),
		.rsp_valid_i (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_rd_i    (rsp_rd_o),
		.rsp_wen_i   (rsp_wen_o),
		.rsp_data_i  (rsp_data_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	initial
	begin
		integer rnd;
		rsp_ready_i = 1'b1;
		forever
		begin
			@(posedge clk_i);
			#1;
			rnd = $random(seed);
			rsp_ready_i = bp_mode ? rnd[0] : 1'b1;
		end
	end

	// a response handshake seen at the falling edge completes on the next rising edge
	initial
	begin
		forever
		begin
			@(negedge clk_i);
			if (rsp_valid_o === 1'b1 && rsp_ready_i === 1'b1)
			begin
				if (exp_q.size() == 0)
				begin
					$display("Error in %s: a response arrived with no request outstanding", cur_test);
					errors++;
				end
				else
					check_value(exp_q.pop_front(), {rsp_wen_o, rsp_rd_o, rsp_data_o});
			end
		end
	end

	task automatic check_value(input logic [37:0] expected, input logic [37:0] actual);
		if (actual !== expected)
		begin
			$display("Fail %s: expected %h, actual %h", cur_test, expected, actual);
			errors++;
		end
	endtask

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic byte_addr_t rand_addr();
		word_t r;
		r = rand_word();
		return {26'b0, r[5:0]};
	endfunction

	// returns {wen, data} and updates the mirrored memory and link bit
	function automatic logic [32:0] model_apply(input mem_op_e op, input byte_addr_t addr,
		input word_t wdata);
		word_t w;
		word_t data;
		logic wen;
		int sh;
		int hs;
		w = model_mem[addr[5:2]];
		data = '0;
		wen = !(op inside {OP_SB, OP_SH, OP_SW});
		sh = 24 - 8 * int'(addr[1:0]);      // lane k occupies bits 31-8k down to 24-8k
		hs = addr[1] ? 0 : 16;
		case (op)
			OP_LB, OP_LBU:
			begin
				data = (w >> sh) & 32'hff;
				if (op == OP_LB && data[7])
					data = data | 32'hffff_ff00;
			end
			OP_LH, OP_LHU:
			begin
				data = addr[0] ? 32'h0 : (w >> hs) & 32'hffff;
				if (op == OP_LH && data[15])
					data = data | 32'hffff_0000;
			end
			OP_SB: model_mem[addr[5:2]] = (w & ~(32'hff << sh)) | ((wdata & 32'hff) << sh);
			OP_SH:
			begin
				if (!addr[0])
					model_mem[addr[5:2]] = (w & ~(32'hffff << hs)) | ((wdata & 32'hffff) << hs);
			end
			OP_SW: model_mem[addr[5:2]] = wdata;
			OP_SC:
			begin
				if (model_link)
					model_mem[addr[5:2]] = wdata;
				data = {31'b0, model_link};
				model_link = 1'b0;
			end
			default:
			begin
				data = w;                        // lw and ll return the whole word
				if (op == OP_LL)
					model_link = 1'b1;
			end
		endcase
		return {wen, data};
	endfunction

	// called 1 ns after a rising edge and returns at the same point
	task automatic send_req(input mem_op_e op, input byte_addr_t addr, input word_t wdata);
		int waited;
		word_t r;
		logic [32:0] res;
		if (timed_out)
			return;
		r = rand_word();
		req_valid_i = 1'b1;
		req_op_i = op;
		req_addr_i = addr;
		req_wdata_i = wdata;
		req_rd_i = r[4:0];
		waited = 0;
		@(negedge clk_i);
		while (req_ready_o !== 1'b1 && waited < SEND_TIMEOUT)
		begin
			@(negedge clk_i);
			waited++;
		end
		if (req_ready_o !== 1'b1)
		begin
			$display("Error in %s: request not accepted within %0d cycles", cur_test, SEND_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end
		else
		begin
			res = model_apply(op, addr, wdata);
			exp_q.push_back({res[32], r[4:0], res[31:0]});
		end
		@(posedge clk_i);
		#1;
		req_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT && !timed_out)
		begin
			@(posedge clk_i);
			#1;
			waited++;
		end
		if (exp_q.size() != 0 && !timed_out)
		begin
			$display("Error in %s: %0d responses missing after %0d cycles", cur_test,
				exp_q.size(), DRAIN_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_start_errors = errors;
	endtask

	task automatic end_test();
		wait_drain();
		if (errors == test_start_errors)
		begin
			$display("test %s: passed", cur_test);
			tests_passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", cur_test, errors - test_start_errors);
			tests_failed++;
		end
	endtask

	initial
	begin
		word_t w;
		byte_addr_t addr;
		rst_i = 1'b1;
		req_valid_i = 1'b0;
		req_op_i = OP_LW;
		req_addr_i = '0;
		req_wdata_i = '0;
		req_rd_i = '0;
		bp_mode = 1'b0;
		timed_out = 1'b0;
		model_link = 1'b0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;

		begin_test("reset");
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk_i);
			#1;
			check_value(38'h1, {36'b0, rsp_valid_o, req_ready_o});   // idle and ready
		end
		rst_i = 1'b0;
		@(posedge clk_i);
		#1;
		check_value(38'h1, {36'b0, rsp_valid_o, req_ready_o});
		end_test();

		begin_test("word_roundtrip");
		for (int i = 0; i < 16; i++)
			send_req(OP_SW, byte_addr_t'(i * 4), rand_word());
		for (int i = 0; i < 16; i++)
			send_req(OP_LW, byte_addr_t'(i * 4), rand_word());
		end_test();

		begin_test("subword_loads");
		for (int i = 0; i < 60; i++)
		begin
			w = rand_word();
			send_req(mem_op_e'({2'b00, w[1:0]}), rand_addr(), rand_word());
		end
		end_test();

		begin_test("subword_stores");
		send_req(OP_SH, 32'h0000_0005, 32'hdead_beef);   // misaligned halfword writes nothing
		send_req(OP_LW, 32'h0000_0004, '0);
		for (int i = 0; i < 40; i++)
		begin
			w = rand_word();
			addr = rand_addr();
			send_req(mem_op_e'(w[0] ? OP_SH : OP_SB), addr, rand_word());
			send_req(OP_LW, addr, '0);
		end
		end_test();

		begin_test("ll_sc");
		send_req(OP_SC, 32'h0000_0008, 32'h1111_1111);   // no ll since reset
		send_req(OP_LL, 32'h0000_0008, '0);
		send_req(OP_SC, 32'h0000_0008, 32'h2222_2222);
		send_req(OP_LW, 32'h0000_0008, '0);
		send_req(OP_SC, 32'h0000_0008, 32'h3333_3333);
		send_req(OP_LW, 32'h0000_0008, '0);
		end_test();

		begin_test("backpressure");
		bp_mode = 1'b1;
		for (int i = 0; i < 300; i++)
		begin
			w = rand_word();
			if (w[31])
			begin
				@(posedge clk_i);
				#1;
			end
			w = w % 10;
			send_req(mem_op_e'(w[3:0]), rand_addr(), rand_word());
		end
		end_test();
		bp_mode = 1'b0;

		repeat (8) @(posedge clk_i);
		$display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* lsu_top.f */
+incdir+source
source/mips_isa_pkg.sv
source/dmem_pkg.sv
source/lsu_access_if.sv
source/lsu_result_if.sv
source/lsu_format_stage.sv
source/lsu_access_stage.sv
source/lsu_writeback_stage.sv
source/lsu_top.sv
tb/lsu_properties.sv
tb/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= lsu_tb
FLIST ?= lsu_top.f
OBJ_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
